// ==== Makefile ====
# Verilator build and run of the decode stage testbench

TOP      ?= tb_decode
FILELIST ?= list.f
BUILD    ?= obj_dir
VFLAGS   ?= --binary --timing --assert

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status and fails this target
sim:
	verilator $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== list.f ====
src/decode_pkg.sv
src/op_decoder.sv
src/imm_gen.sv
src/hazard_ctrl.sv
src/stage_reg.sv
src/decode_top.sv
tests/tb_decode.sv

// ==== src/decode_pkg.sv ====
////////////////////
// RV32I decode types. The upper three bits of op_e carry the unit code
// and ALU operations span codes 000 and 001
////////////////////
package decode_pkg;

    // Executing unit of a decoded operation
    typedef enum logic [2:0] {
        ALU_UNIT    = 3'b000,
        BRANCH_UNIT = 3'b010,
        MEMORY_UNIT = 3'b011,
        BYPASS_UNIT = 3'b100
    } unit_e;

    typedef enum logic [5:0] {
        ADD     = 6'b000_000,
        SUB     = 6'b000_001,
        SLT     = 6'b000_010,
        SLTU    = 6'b000_011,
        XOR     = 6'b000_100,
        OR      = 6'b000_101,
        AND     = 6'b000_110,
        SLL     = 6'b001_000,                   // Shifts in second ALU code
        SRL     = 6'b001_001,
        SRA     = 6'b001_010,
        BEQ     = 6'b010_000,
        BNE     = 6'b010_001,
        BLT     = 6'b010_010,
        BGE     = 6'b010_011,
        BLTU    = 6'b010_100,
        BGEU    = 6'b010_101,
        JAL     = 6'b010_110,
        JALR    = 6'b010_111,
        LB      = 6'b011_000,
        LH      = 6'b011_001,
        LW      = 6'b011_010,
        LBU     = 6'b011_011,
        LHU     = 6'b011_100,
        SB      = 6'b011_101,
        SH      = 6'b011_110,
        SW      = 6'b011_111,
        NOP     = 6'b100_000,
        LUI     = 6'b100_001,
        INVALID = 6'b100_111
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    ////////////////////
    // Major opcodes
    ////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    // Recovers the unit from the top bits of the operation
    function automatic unit_e unit_of(input op_e op);
        unit_e unit;
        case (op[5:3])
            3'b000, 3'b001: unit = ALU_UNIT;
            3'b010:         unit = BRANCH_UNIT;
            3'b011:         unit = MEMORY_UNIT;
            default:        unit = BYPASS_UNIT;
        endcase
        return unit;
    endfunction

endpackage

// ==== src/decode_top.sv ====
////////////////////
// Decode stage of a five-stage RV32I pipeline. No CSR or system support
////////////////////
module decode_top import decode_pkg::*; #(
    parameter int TAG_W = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall_i,
    input  logic [31:0]      instruction_i,
    input  logic [31:0]      pc_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic [31:0]      rs1_data_i,             // Register file read data
    input  logic [31:0]      rs2_data_i,
    output logic [4:0]       rs1_o,                  // Register file read addresses
    output logic [4:0]       rs2_o,
    output logic [4:0]       rd_o,                   // Write address, two accepted edges late
    output logic [31:0]      first_operand_o,
    output logic [31:0]      second_operand_o,
    output logic [31:0]      third_operand_o,
    output logic [31:0]      pc_o,
    output logic [31:0]      instruction_o,
    output logic [TAG_W-1:0] tag_o,
    output op_e              operation_o,
    output logic             hazard_o,
    output logic             exception_o
);

    logic [31:0] dec_instr;                          // Fetched or replayed word
    op_e         dec_op;
    format_e     dec_format;
    logic [31:0] dec_imm;

    hazard_ctrl u_hazard_ctrl (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .op_i          (dec_op),
        .instr_o       (dec_instr),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    op_decoder u_op_decoder (
        .instr_i  (dec_instr),
        .op_o     (dec_op),
        .format_o (dec_format)
    );

    imm_gen u_imm_gen (
        .instr_i  (dec_instr),
        .format_i (dec_format),
        .imm_o    (dec_imm)
    );

    stage_reg #(
        .TAG_W (TAG_W)
    ) u_stage_reg (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .hazard_i         (hazard_o),
        .instr_i          (dec_instr),
        .op_i             (dec_op),
        .format_i         (dec_format),
        .imm_i            (dec_imm),
        .pc_i             (pc_i),
        .tag_i            (tag_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .instruction_o    (instruction_o),
        .tag_o            (tag_o),
        .operation_o      (operation_o),
        .exception_o      (exception_o)
    );

endmodule

// ==== src/hazard_ctrl.sv ====
////////////////////
// Upstream must hold pc and tag for one cycle after hazard_o so the
// held word replays with its own pc
////////////////////
module hazard_ctrl import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  logic [31:0] instruction_i,
    input  op_e         op_i,
    output logic [31:0] instr_o,
    output logic [4:0]  rs1_o,
    output logic [4:0]  rs2_o,
    output logic [4:0]  rd_o,
    output logic        hazard_o
);

    logic [31:0]     held_instr;
    logic            held_hazard;
    logic [4:0]      target;
    logic            target_store;
    logic [1:0][4:0] lock_reg;                      // Slot 0 is the newest
    logic [1:0]      lock_store;
    logic            store_dep;
    logic            rs1_dep;
    logic            rs2_dep;

    ////////////////////
    // Replay
    ////////////////////
    always_ff @(posedge clk) begin
        held_instr <= instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_hazard <= 1'b0;
        end else begin
            held_hazard <= hazard_o;
        end
    end

    assign instr_o = held_hazard ? held_instr : instruction_i;

    assign rs1_o = instr_o[19:15];
    assign rs2_o = instr_o[24:20];
    assign rd_o  = lock_reg[1];

    // A bubble locks nothing
    assign target       = hazard_o ? 5'd0 : instr_o[11:7];
    assign target_store = !hazard_o && (op_i == SB || op_i == SH || op_i == SW);

    ////////////////////
    // Lock queue
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            lock_reg   <= '0;
            lock_store <= '0;
        end else if (!stall_i) begin
            lock_reg   <= {lock_reg[0], target};
            lock_store <= {lock_store[0], target_store};
        end
    end

    assign store_dep = (lock_store[0] || lock_store[1]) && (unit_of(op_i) == MEMORY_UNIT);
    assign rs1_dep   = (lock_reg[0] == rs1_o) && (rs1_o != 5'd0);
    assign rs2_dep   = (lock_reg[0] == rs2_o) && (rs2_o != 5'd0);   // Checked for any format
    assign hazard_o  = store_dep || rs1_dep || rs2_dep;

    a_queue_frozen_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall_i |=> ($stable(lock_reg) && $stable(lock_store))
    ) else $error("lock queue moved while stalled");

endmodule

// ==== src/imm_gen.sv ====
////////////////////
// Immediates per RV32I. R format gives zero
////////////////////
module imm_gen import decode_pkg::*; (
    input  logic [31:0] instr_i,
    input  format_e     format_i,
    output logic [31:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (format_i)
            I_TYPE: begin
                imm_o = {{21{sign}}, instr_i[30:20]};
            end
            S_TYPE: begin
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};   // Split field
            end
            B_TYPE: begin
                imm_o = {{20{sign}},
                         instr_i[7],
                         instr_i[30:25],
                         instr_i[11:8],
                         1'b0};                                         // Halfword aligned
            end
            U_TYPE: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            J_TYPE: begin
                imm_o = {{12{sign}},
                         instr_i[19:12],
                         instr_i[20],
                         instr_i[30:21],
                         1'b0};
            end
            default: begin
                imm_o = '0;                                             // No immediate
            end
        endcase
    end

endmodule

// ==== src/op_decoder.sv ====
////////////////////
// RV32I base set only. System and CSR words come out as INVALID
////////////////////
module op_decoder import decode_pkg::*; (
    input  logic [31:0] instr_i,
    output op_e         op_o,
    output format_e     format_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////
    // Operation table
    ////////////////////
    always_comb begin
        op_o = INVALID;
        case (opcode)
            OPC_LUI:   op_o = LUI;
            OPC_AUIPC: op_o = ADD;                  // pc plus upper immediate
            OPC_JAL:   op_o = JAL;
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op_o = JALR;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_o = BEQ;
                    3'b001:  op_o = BNE;
                    3'b100:  op_o = BLT;
                    3'b101:  op_o = BGE;
                    3'b110:  op_o = BLTU;
                    3'b111:  op_o = BGEU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op_o = LB;
                    3'b001:  op_o = LH;
                    3'b010:  op_o = LW;
                    3'b100:  op_o = LBU;
                    3'b101:  op_o = LHU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op_o = SB;
                    3'b001:  op_o = SH;
                    3'b010:  op_o = SW;
                    default: op_o = INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                if (instr_i == 32'h0000_0013) begin
                    op_o = NOP;                     // Canonical addi x0, x0, 0
                end else begin
                    case (funct3)
                        3'b000:  op_o = ADD;
                        3'b010:  op_o = SLT;
                        3'b011:  op_o = SLTU;
                        3'b100:  op_o = XOR;
                        3'b110:  op_o = OR;
                        3'b111:  op_o = AND;
                        3'b001:  op_o = (funct7 == 7'b0000000) ? SLL : INVALID;
                        3'b101: begin
                            if (funct7 == 7'b0000000) begin
                                op_o = SRL;
                            end else if (funct7 == 7'b0100000) begin
                                op_o = SRA;
                            end
                        end
                        default: op_o = INVALID;
                    endcase
                end
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op_o = ADD;
                    {7'b0100000, 3'b000}: op_o = SUB;
                    {7'b0000000, 3'b001}: op_o = SLL;
                    {7'b0000000, 3'b010}: op_o = SLT;
                    {7'b0000000, 3'b011}: op_o = SLTU;
                    {7'b0000000, 3'b100}: op_o = XOR;
                    {7'b0000000, 3'b101}: op_o = SRL;
                    {7'b0100000, 3'b101}: op_o = SRA;
                    {7'b0000000, 3'b110}: op_o = OR;
                    {7'b0000000, 3'b111}: op_o = AND;
                    default:              op_o = INVALID;
                endcase
            end
            OPC_FENCE: begin
                if (funct3 == 3'b000) begin
                    op_o = NOP;                     // Single hart needs no ordering
                end
            end
            default: op_o = INVALID;
        endcase
    end

    // Format follows the major opcode alone
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: format_o = I_TYPE;
            OPC_STORE:                      format_o = S_TYPE;
            OPC_BRANCH:                     format_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             format_o = U_TYPE;
            OPC_JAL:                        format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

endmodule

// ==== src/stage_reg.sv ====
////////////////////
// Stall outranks hazard. A bubble keeps the incoming tag
////////////////////
module stage_reg import decode_pkg::*; #(
    parameter int TAG_W = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall_i,
    input  logic             hazard_i,
    input  logic [31:0]      instr_i,
    input  op_e              op_i,
    input  format_e          format_i,
    input  logic [31:0]      imm_i,
    input  logic [31:0]      pc_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic [31:0]      rs1_data_i,
    input  logic [31:0]      rs2_data_i,
    output logic [31:0]      first_operand_o,
    output logic [31:0]      second_operand_o,
    output logic [31:0]      third_operand_o,
    output logic [31:0]      pc_o,
    output logic [31:0]      instruction_o,
    output logic [TAG_W-1:0] tag_o,
    output op_e              operation_o,
    output logic             exception_o
);

    logic [31:0] first_operand;
    logic [31:0] second_operand;
    logic [31:0] third_operand;

    ////////////////////
    // Operand select
    ////////////////////
    always_comb begin
        first_operand  = (format_i == U_TYPE || format_i == J_TYPE) ? pc_i : rs1_data_i;
        second_operand = (format_i == R_TYPE || format_i == B_TYPE) ? rs2_data_i : imm_i;
        third_operand  = (format_i == S_TYPE) ? rs2_data_i : imm_i;   // Store data
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instruction_o    <= '0;
            tag_o            <= '0;
            operation_o      <= NOP;
            exception_o      <= 1'b0;
        end else if (!stall_i) begin
            if (hazard_i) begin                     // Bubble
                first_operand_o  <= '0;
                second_operand_o <= '0;
                third_operand_o  <= '0;
                pc_o             <= '0;
                instruction_o    <= '0;
                tag_o            <= tag_i;
                operation_o      <= NOP;
                exception_o      <= 1'b0;
            end else begin
                first_operand_o  <= first_operand;
                second_operand_o <= second_operand;
                third_operand_o  <= third_operand;
                pc_o             <= pc_i;
                instruction_o    <= instr_i;
                tag_o            <= tag_i;
                operation_o      <= op_i;
                exception_o      <= (op_i == INVALID);
            end
        end
    end

    a_bubble_is_nop: assert property (
        @(posedge clk) disable iff (reset)
        (hazard_i && !stall_i) |=> (operation_o == NOP)
    ) else $error("hazard did not produce a bubble");

    a_no_nop_exception: assert property (
        @(posedge clk) disable iff (reset)
        !(exception_o && operation_o == NOP)
    ) else $error("exception raised on a NOP");

endmodule

// ==== tests/tb_decode.sv ====
////////////////////
// Directed tests with a cycle model of the lock queue and replay.
// Stimulus must hold pc and tag while a hazard replays
////////////////////
module tb_decode import decode_pkg::*; ();

    localparam int          TAG_W       = 3;
    localparam int          TEST_CYCLES = 200;              // Rough length of all tests
    localparam int          TIMEOUT     = 5 * TEST_CYCLES;
    localparam logic [31:0] SEED        = 32'h9288;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

    logic clk;
    logic reset;
    logic stall_i;
    logic [31:0] instruction_i;
    logic [31:0] pc_i;
    logic [TAG_W-1:0] tag_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [4:0] rs1_o;
    logic [4:0] rs2_o;
    logic [4:0] rd_o;
    logic [31:0] first_operand_o;
    logic [31:0] second_operand_o;
    logic [31:0] third_operand_o;
    logic [31:0] pc_o;
    logic [31:0] instruction_o;
    logic [TAG_W-1:0] tag_o;
    op_e operation_o;
    logic hazard_o;
    logic exception_o;

    logic [31:0] regs [32];                                 // Register file model
    logic [4:0] lk_reg [2];                                 // Lock queue model
    logic lk_st [2];
    logic [31:0] held_word;
    logic replay;
    logic [31:0] e_first;                                   // Expected registered outputs
    logic [31:0] e_second;
    logic [31:0] e_third;
    logic [31:0] e_pc;
    logic [31:0] e_instr;
    logic [TAG_W-1:0] e_tag;
    op_e e_op;
    logic e_exc;
    logic [31:0] cur_pc;
    int cycles;

    decode_top #(.TAG_W(TAG_W)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Verification failed");
            $fatal(1, "Timeout after %0d cycles, the tests did not finish", TIMEOUT);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    ////////////////////
    // Instruction encoders
    ////////////////////
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    ////////////////////
    // Reference decode
    ////////////////////
    function automatic op_e ref_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic is_op;
        logic f7_used;
        logic f7_alt;
        op_e op;
        f3 = w[14:12];
        f7 = w[31:25];
        is_op = (w[6:0] == OPC_OP);
        f7_used = is_op || f3 == 3'd1 || f3 == 3'd5;
        f7_alt = (f7 == 7'h20) && (f3 == 3'd5 || (is_op && f3 == 3'd0));
        op = INVALID;
        case (w[6:0])
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = ADD;
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = (f3 == 3'd0) ? JALR : INVALID;
            OPC_FENCE: op = (f3 == 3'd0) ? NOP : INVALID;
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    op = BEQ;
                    3'd1:    op = BNE;
                    3'd4:    op = BLT;
                    3'd5:    op = BGE;
                    3'd6:    op = BLTU;
                    3'd7:    op = BGEU;
                    default: op = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0:    op = LB;
                    3'd1:    op = LH;
                    3'd2:    op = LW;
                    3'd4:    op = LBU;
                    3'd5:    op = LHU;
                    default: op = INVALID;
                endcase
            end
            OPC_STORE: op = (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : (f3 == 3'd2) ? SW : INVALID;
            OPC_OP, OPC_OP_IMM: begin
                case (f3)
                    3'd0:    op = (is_op && f7 == 7'h20) ? SUB : ADD;
                    3'd1:    op = SLL;
                    3'd2:    op = SLT;
                    3'd3:    op = SLTU;
                    3'd4:    op = XOR;
                    3'd5:    op = f7[5] ? SRA : SRL;
                    3'd6:    op = OR;
                    default: op = AND;
                endcase
                if (f7_used && f7 != 7'h00 && !f7_alt) begin
                    op = INVALID;                           // Reserved funct7
                end
                if (w == NOP_WORD) begin
                    op = NOP;
                end
            end
            default: op = INVALID;
        endcase
        return op;
    endfunction

    function automatic format_e ref_fmt(input logic [31:0] w);
        case (w[6:0])
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w, input format_e fmt);
        case (fmt)
            I_TYPE:  return 32'($signed(w[31:20]));
            S_TYPE:  return 32'($signed({w[31:25], w[11:7]}));
            B_TYPE:  return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic ref_hazard(input logic [31:0] w);
        logic mem_dep;
        logic rs1_dep;
        logic rs2_dep;
        mem_dep = (lk_st[0] || lk_st[1]) && (ref_op(w) inside {LB, LH, LW, LBU, LHU, SB, SH, SW});
        rs1_dep = (w[19:15] != 5'd0) && (w[19:15] == lk_reg[0]);
        rs2_dep = (w[24:20] != 5'd0) && (w[24:20] == lk_reg[0]);
        return mem_dep || rs1_dep || rs2_dep;
    endfunction

    // Moves the model across the edge that ends the cycle of word w
    task automatic advance(input logic [31:0] w, input logic [31:0] pc,
                           input logic [TAG_W-1:0] tag, input logic stall);
        op_e op;
        format_e fmt;
        logic [31:0] imm;
        logic haz;
        op = ref_op(w);
        fmt = ref_fmt(w);
        imm = ref_imm(w, fmt);
        haz = ref_hazard(w);
        if (!stall) begin
            e_tag = tag;
            e_op = haz ? NOP : op;
            e_exc = !haz && op == INVALID;
            e_pc = haz ? 32'd0 : pc;
            e_instr = haz ? 32'd0 : w;
            e_first = (fmt == U_TYPE || fmt == J_TYPE) ? pc : regs[w[19:15]];
            e_second = (fmt == R_TYPE || fmt == B_TYPE) ? regs[w[24:20]] : imm;
            e_third = (fmt == S_TYPE) ? regs[w[24:20]] : imm;
            if (haz) begin
                e_first = 32'd0;
                e_second = 32'd0;
                e_third = 32'd0;
            end
            lk_reg[1] = lk_reg[0];
            lk_st[1] = lk_st[0];
            lk_reg[0] = haz ? 5'd0 : w[11:7];
            lk_st[0] = !haz && (op inside {SB, SH, SW});
        end
        held_word = w;                                      // Recorded even under stall
        replay = haz;
    endtask

    // One cycle: drive on the rising edge, check at the falling edge
    task automatic step(input logic [31:0] instr, input logic [31:0] pc,
                        input logic [TAG_W-1:0] tag, input logic stall);
        logic [31:0] w;
        w = replay ? held_word : instr;
        @(posedge clk);
        instruction_i <= instr;
        pc_i <= pc;
        tag_i <= tag;
        stall_i <= stall;
        rs1_data_i <= regs[w[19:15]];
        rs2_data_i <= regs[w[24:20]];
        @(negedge clk);
        check("operation_o", 32'(operation_o), 32'(e_op));
        check("exception_o", 32'(exception_o), 32'(e_exc));
        check("first_operand_o", first_operand_o, e_first);
        check("second_operand_o", second_operand_o, e_second);
        check("third_operand_o", third_operand_o, e_third);
        check("pc_o", pc_o, e_pc);
        check("instruction_o", instruction_o, e_instr);
        check("tag_o", 32'(tag_o), 32'(e_tag));
        check("rs1_o", 32'(rs1_o), 32'(w[19:15]));
        check("rs2_o", 32'(rs2_o), 32'(w[24:20]));
        check("rd_o", 32'(rd_o), 32'(lk_reg[1]));
        check("hazard_o", 32'(hazard_o), 32'(ref_hazard(w)));
        advance(w, pc, tag, stall);
    endtask

    // pc moves on only when the word was accepted
    task automatic issue(input logic [31:0] w, input logic stall);
        step(w, cur_pc, cur_pc[TAG_W+1:2], stall);
        if (!stall && !replay) begin
            cur_pc = cur_pc + 32'd4;
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset();
        @(negedge clk);
        check("operation_o", 32'(operation_o), 32'(NOP));
        check("first_operand_o", first_operand_o, 32'd0);
        check("second_operand_o", second_operand_o, 32'd0);
        check("third_operand_o", third_operand_o, 32'd0);
        check("tag_o", 32'(tag_o), 32'd0);
        check("exception_o", 32'(exception_o), 32'd0);
        check("rd_o", 32'(rd_o), 32'd0);
        advance(NOP_WORD, 32'd0, '0, 1'b0);                 // Idle cycle after release
    endtask

    task automatic test_formats();
        logic [31:0] words[$];
        words.push_back(enc_r(0, 3, 2, 0, 1));              // add
        words.push_back(enc_r(32, 6, 5, 0, 4));             // sub
        words.push_back(enc_r(32, 23, 22, 5, 24));          // sra
        words.push_back(enc_r(0, 26, 25, 6, 27));
        words.push_back(enc_i(-5, 8, 0, 7, OPC_OP_IMM));
        words.push_back(enc_i(100, 3, 3, 9, OPC_OP_IMM));   // sltiu
        words.push_back(enc_i(1024 + 5, 11, 5, 12, OPC_OP_IMM));
        words.push_back(enc_i(-12, 12, 2, 11, OPC_LOAD));
        words.push_back(enc_i(2047, 13, 4, 14, OPC_LOAD));  // lbu
        words.push_back(enc_i(16, 2, 0, 1, OPC_JALR));
        words.push_back(enc_s(-20, 13, 14, 2));             // Stores after loads
        words.push_back(enc_s(5, 15, 16, 0));
        words.push_back(enc_b(-8, 2, 1, 0));
        words.push_back(enc_b(-4096, 12, 11, 7));           // bgeu
        words.push_back(enc_b(12, 4, 3, 1));
        words.push_back(enc_u(32'hABCDE, 15, OPC_LUI));
        words.push_back(enc_u(32'h80000, 16, OPC_AUIPC));
        words.push_back(enc_j(-1024, 1));
        foreach (words[i]) begin
            issue(words[i], 1'b0);
            issue(NOP_WORD, 1'b0);
        end
    endtask

    task automatic test_unsupported();
        logic [31:0] words[$];
        words.push_back(enc_i(12'h300, 2, 1, 1, 7'h73));    // csrrw
        words.push_back(32'h0000_0073);                     // ecall
        words.push_back(32'h3020_0073);                     // mret
        words.push_back(32'hFFFF_FFFF);
        foreach (words[i]) begin
            issue(words[i], 1'b0);
            issue(NOP_WORD, 1'b0);
            check("operation_o", 32'(operation_o), 32'(INVALID));
            check("exception_o", 32'(exception_o), 32'd1);
        end
        issue(32'h0FF0_000F, 1'b0);                         // fence
        issue(NOP_WORD, 1'b0);
        check("operation_o", 32'(operation_o), 32'(NOP));
        check("exception_o", 32'(exception_o), 32'd0);
    endtask

    task automatic test_reg_hazard();
        logic [31:0] use_x5;
        logic [TAG_W-1:0] use_tag;
        use_x5 = enc_r(0, 2, 5, 0, 6);                      // add x6, x5, x2
        issue(NOP_WORD, 1'b0);
        issue(enc_i(7, 1, 0, 5, OPC_OP_IMM), 1'b0);         // addi x5, x1, 7
        use_tag = cur_pc[TAG_W+1:2];
        issue(use_x5, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd1);
        issue(use_x5, 1'b0);                                // Replay cycle
        check("operation_o", 32'(operation_o), 32'(NOP));
        check("tag_o", 32'(tag_o), 32'(use_tag));
        check("hazard_o", 32'(hazard_o), 32'd0);
        check("rd_o", 32'(rd_o), 32'd5);
        issue(NOP_WORD, 1'b0);
        check("operation_o", 32'(operation_o), 32'(ADD));
        check("instruction_o", instruction_o, use_x5);
        check("rd_o", 32'(rd_o), 32'd0);
        issue(NOP_WORD, 1'b0);
        check("rd_o", 32'(rd_o), 32'd6);
    endtask

    task automatic test_store_hazard();
        logic [31:0] sw_w;
        logic [31:0] lw_w;
        sw_w = enc_s(8, 3, 1, 2);
        lw_w = enc_i(0, 2, 2, 7, OPC_LOAD);
        issue(NOP_WORD, 1'b0);
        issue(NOP_WORD, 1'b0);
        issue(sw_w, 1'b0);
        issue(lw_w, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd1);
        issue(lw_w, 1'b0);                                  // Store now in slot 1
        check("hazard_o", 32'(hazard_o), 32'd1);
        issue(lw_w, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd0);
        issue(NOP_WORD, 1'b0);
        issue(NOP_WORD, 1'b0);
        issue(sw_w, 1'b0);
        issue(enc_r(0, 11, 10, 0, 9), 1'b0);
        issue(lw_w, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd1);
        issue(lw_w, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd0);
        issue(NOP_WORD, 1'b0);
        issue(NOP_WORD, 1'b0);
        issue(sw_w, 1'b0);
        issue(enc_r(0, 11, 10, 0, 9), 1'b0);
        issue(enc_r(0, 11, 10, 0, 13), 1'b0);
        issue(lw_w, 1'b0);
        check("hazard_o", 32'(hazard_o), 32'd0);
    endtask

    task automatic test_stall();
        logic [31:0] snap_instr;
        logic [31:0] snap_first;
        logic [4:0] snap_rd;
        logic [31:0] xor_w;
        xor_w = enc_r(0, 3, 2, 4, 14);                      // xor x14, x2, x3
        snap_instr = enc_i(3, 1, 0, 12, OPC_OP_IMM);        // addi x12, x1, 3
        issue(NOP_WORD, 1'b0);
        issue(NOP_WORD, 1'b0);
        issue(snap_instr, 1'b0);
        issue(enc_i(1, 1, 0, 13, OPC_OP_IMM), 1'b1);
        snap_first = regs[1];
        snap_rd = lk_reg[1];
        for (int k = 0; k < 4; k++) begin
            issue(enc_i(k + 2, 2, 4, 15 + k, OPC_OP_IMM), 1'b1);
            check("instruction_o", instruction_o, snap_instr);
            check("first_operand_o", first_operand_o, snap_first);
            check("rd_o", 32'(rd_o), 32'(snap_rd));
        end
        issue(xor_w, 1'b0);                                 // Edge still saw stall
        check("instruction_o", instruction_o, snap_instr);
        issue(NOP_WORD, 1'b0);
        check("instruction_o", instruction_o, xor_w);
        check("operation_o", 32'(operation_o), 32'(XOR));
    endtask

    initial begin
        void'($urandom(SEED));
        cycles = 0;
        reset = 1'b1;
        stall_i = 1'b0;
        instruction_i = NOP_WORD;
        pc_i = 32'd0;
        tag_i = '0;
        rs1_data_i = 32'd0;
        rs2_data_i = 32'd0;
        regs[0] = 32'd0;
        for (int i = 1; i < 32; i++) begin
            regs[i] = $urandom;
        end
        lk_reg[0] = 5'd0;
        lk_reg[1] = 5'd0;
        lk_st[0] = 1'b0;
        lk_st[1] = 1'b0;
        held_word = 32'd0;
        replay = 1'b0;
        cur_pc = 32'h0000_0100;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_formats();
        test_unsupported();
        test_reg_hazard();
        test_store_hazard();
        test_stall();
        $display("Verification passed");
        $finish;
    end

endmodule
